/* verification/video_trace.txt */
# first data line: expected first upload base, expected first download base (decimal words)
# then one line per frame: pixel seed (hex), store-full start word, store-full length (cycles)
# a length of 0 means the store queue never goes full in that frame
0 96
a3c10000 0 0
5e7b1200 10 12
00f0a3d0 0 6
7c2e9100 33 40
1b4d0070 5 0
e2a05500 48 9
39cc0e10 20 25
8814f300 0 0
c6d20a80 62 15
0a9be440 8 3
f1370020 40 60
4d6c8b00 17 0
2fe01c90 0 30
91a75e00 56 7
60bb2d40 26 18
d5480f10 0 0
3e9a7700 12 50
a7c35a20 44 11
12f08e60 3 2
bc5d4100 30 22

/* filelist.f */
source/video_mem_pkg.sv
source/frame_buffer_pkg.sv
source/access_arbiter.sv
source/buffer_table.sv
source/frame_sequencer.sv
source/frame_uploader.sv
source/frame_downloader.sv
source/video_controller.sv
verification/tb_video_controller.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

TOP=tb_video_controller
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" \
        -Mdir obj_dir -f filelist.f; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/V"$TOP" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error status"
    exit 1
fi
cat "$LOG"

if grep -qx "Finished with no errors" "$LOG"; then
    exit 0
fi
echo "simulation reported failures, see $LOG"
exit 1

/* verification/tb_video_controller.sv */
`timescale 1ns/1ps

module tb_video_controller;

    import video_mem_pkg::*;

    localparam int MEM_WORDS = 1024;
    localparam int RESET_CYCLES = 16;
    localparam int INIT_LAG = 10;
    // idle cycles between a read command and its first word
    localparam int RESP_GAP = 3;

    logic clk;
    logic rst_n;
    logic init_done;
    logic [MEM_DATA_W-1:0] rd_data;
    logic rd_data_valid;
    logic [MEM_ADDR_W-1:0] addr;
    logic cmd;
    logic cmd_en;
    logic [MEM_DATA_W-1:0] wr_data;
    logic load_read_rdy;
    logic [PIXEL_ADDR_W-1:0] load_mem_addr;
    logic load_pixel_valid;
    logic [MEM_DATA_W-1:0] load_pixel_data;
    logic store_wr_en;
    logic store_queue_full;
    logic [STORE_DATA_W-1:0] store_queue_data;
    logic error_flag;

    logic [MEM_DATA_W-1:0] mem [MEM_WORDS];
    logic [MEM_DATA_W-1:0] seeds [$];
    int full_start [$];
    int full_len [$];
    int pend_q [$];
    int ret_q [$];
    int num_frames = 0;
    int exp_up_base = 0;
    int exp_dl_base = 0;
    int init_edges = 0;
    int writes = 0;
    int read_words = 0;
    int stores = 0;
    int up_base = 0;
    int dl_base = 0;
    bit dl_active = 1'b0;
    int resp_wait = 0;
    int full_left = 0;
    int full_frame = -1;
    int stores_in_full = 0;
    int mismatches = 0;
    int failures = 0;
    bit trace_loaded = 1'b0;

    video_controller dut0 (
        .clk(clk), .rst_n(rst_n), .init_done_i(init_done), .rd_data_i(rd_data),
        .rd_data_valid_i(rd_data_valid), .addr_o(addr), .cmd_o(cmd), .cmd_en_o(cmd_en),
        .wr_data_o(wr_data), .load_read_rdy_o(load_read_rdy), .load_mem_addr_o(load_mem_addr),
        .load_pixel_valid_i(load_pixel_valid), .load_pixel_data_i(load_pixel_data),
        .store_wr_en_o(store_wr_en), .store_queue_full_i(store_queue_full),
        .store_queue_data_o(store_queue_data), .error_o(error_flag)
    );

    task automatic check_value(input string name, input longint expected, input longint actual);
        if (expected != actual) begin
            mismatches++;
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    task automatic note_failure(input string what);
        failures++;
        $display("at %0t: %s", $time, what);
    endtask

    task automatic report_counts();
        $display("error count: %0d value mismatches, %0d other failures", mismatches, failures);
    endtask

    // odd multiplier keeps every word distinct
    task automatic fill_memory();
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = MEM_DATA_W'(a) * 32'h9e37_79b1 + 32'h1f2e_3d4c;
        end
    endtask

    task automatic load_trace();
        int fd;
        int n;
        int a;
        int b;
        int st;
        int ln;
        logic [MEM_DATA_W-1:0] s;
        string line;
        bit header;
        header = 1'b1;
        fd = $fopen("verification/video_trace.txt", "r");
        if (fd == 0) begin
            note_failure("cannot open verification/video_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line[0] != "#") begin
                    if (header) begin
                        if ($sscanf(line, "%d %d", a, b) == 2) begin
                            exp_up_base = a;
                            exp_dl_base = b;
                            header = 1'b0;
                        end
                    end else if ($sscanf(line, "%h %d %d", s, st, ln) == 3) begin
                        seeds.push_back(s);
                        full_start.push_back(st);
                        full_len.push_back(ln);
                    end
                end
            end
            $fclose(fd);
        end
        num_frames = seeds.size();
        if (num_frames == 0) begin
            note_failure("the trace file holds no frames");
        end
        trace_loaded = 1'b1;
    endtask

    task automatic check_write();
        int frame;
        int offset;
        frame = writes / FRAME_WORDS;
        offset = writes % FRAME_WORDS;
        if (offset == 0) begin
            up_base = int'(addr);
            if (frame == 0) begin
                check_value("first upload base", exp_up_base, up_base);
            end
            check_value($sformatf("upload base alignment, frame %0d", frame), 0,
                        up_base % BUFFER_STRIDE);
        end
        check_value($sformatf("write address, frame %0d", frame), up_base + offset, int'(addr));
        check_value($sformatf("load buffer index, frame %0d", frame), offset, load_mem_addr);
        check_value($sformatf("write data, frame %0d", frame),
                    seeds[frame % num_frames] + MEM_DATA_W'(offset), wr_data);
        if (dl_active && int'(addr) >= dl_base && int'(addr) < dl_base + FRAME_WORDS) begin
            note_failure("write landed in the buffer that is being downloaded");
        end
        if (int'(addr) < MEM_WORDS) begin
            mem[int'(addr)] = wr_data;
        end else begin
            note_failure("write address lies outside the memory model");
        end
        writes++;
    endtask

    task automatic check_read();
        int frame;
        int offset;
        frame = read_words / FRAME_WORDS;
        offset = read_words % FRAME_WORDS;
        if (pend_q.size() + ret_q.size() != 0) begin
            note_failure("read command issued while a burst was still outstanding");
        end
        if (offset == 0) begin
            dl_base = int'(addr);
            dl_active = 1'b1;
            if (frame == 0) begin
                check_value("first download base", exp_dl_base, dl_base);
            end
            check_value($sformatf("download base alignment, frame %0d", frame), 0,
                        dl_base % BUFFER_STRIDE);
        end
        check_value($sformatf("read address, frame %0d", frame), dl_base + offset, int'(addr));
        if (int'(addr) + MEMORY_BURST > MEM_WORDS) begin
            note_failure("read burst runs past the end of the memory model");
        end else begin
            for (int i = 0; i < MEMORY_BURST; i++) begin
                pend_q.push_back(int'(addr) + i);
            end
        end
        resp_wait = RESP_GAP;
        read_words += MEMORY_BURST;
    endtask

    task automatic check_store();
        int a;
        logic eof_expected;
        if (ret_q.size() == 0) begin
            note_failure("store write without a returned memory word");
        end else begin
            a = ret_q.pop_front();
            eof_expected = ((stores + 1) % FRAME_WORDS) == 0;
            check_value($sformatf("store pixel, word %0d", stores), mem[a][STORE_DATA_W-2:0],
                        store_queue_data[STORE_DATA_W-2:0]);
            check_value($sformatf("end of frame flag, word %0d", stores), eof_expected,
                        store_queue_data[STORE_DATA_W-1]);
            stores++;
            if (eof_expected) begin
                dl_active = 1'b0;
            end
            if (store_queue_full) begin
                stores_in_full++;
                if (stores_in_full == MEMORY_BURST + 1) begin
                    note_failure("more than one burst was stored after the queue went full");
                end
            end
        end
    endtask

    task automatic drive_load_buffer();
        int frame;
        frame = writes / FRAME_WORDS;
        load_pixel_valid = 1'b0;
        load_pixel_data = '0;
        if (load_read_rdy && num_frames > 0) begin
            load_pixel_valid = ($urandom % 4) != 0;
            load_pixel_data = seeds[frame % num_frames] + MEM_DATA_W'(load_mem_addr);
        end
    endtask

    task automatic drive_read_data();
        int a;
        rd_data_valid = 1'b0;
        if (pend_q.size() > 0) begin
            if (resp_wait > 0) begin
                resp_wait--;
            end else begin
                a = pend_q.pop_front();
                rd_data = mem[a];
                rd_data_valid = 1'b1;
                ret_q.push_back(a);
            end
        end
    endtask

    // one full window per download frame
    task automatic drive_store_full();
        int frame;
        frame = stores / FRAME_WORDS;
        if (full_left > 0) begin
            full_left--;
        end else begin
            store_queue_full = 1'b0;
            if (frame < num_frames && frame != full_frame && full_len[frame] > 0 &&
                stores % FRAME_WORDS >= full_start[frame]) begin
                full_frame = frame;
                full_left = full_len[frame] - 1;
                stores_in_full = 0;
                store_queue_full = 1'b1;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        void'($urandom(32'h3ba3_6a97));
        rd_data = '0;
        rd_data_valid = 1'b0;
        load_pixel_valid = 1'b0;
        load_pixel_data = '0;
        store_queue_full = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            drive_load_buffer();
            drive_read_data();
            drive_store_full();
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            check_value("error_o", 0, error_flag);
            if (init_edges < MEMORY_INITIAL_DELAY) begin
                check_value("cmd_en_o before start-up", 0, cmd_en);
                check_value("store_wr_en_o before start-up", 0, store_wr_en);
            end
            if (init_done) begin
                init_edges++;
            end
            // a write exactly when a ready pixel is valid
            check_value("write on ready and valid pixel", load_read_rdy && load_pixel_valid,
                        cmd_en && cmd);
            if (store_queue_full) begin
                check_value("read command while store queue full", 0, cmd_en && !cmd);
            end
            if (store_wr_en) begin
                check_store();
            end
            if (cmd_en && cmd) begin
                check_write();
            end
            if (cmd_en && !cmd) begin
                check_read();
            end
        end
    end

    initial begin
        wait (trace_loaded);
        repeat (RESET_CYCLES + INIT_LAG + MEMORY_INITIAL_DELAY +
                num_frames * 4 * FRAME_WORDS * 20) @(posedge clk);
        $display("timeout: %0d of %0d frames reached the store queue", stores / FRAME_WORDS,
                 num_frames);
        report_counts();
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        init_done = 1'b0;
        fill_memory();
        load_trace();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (INIT_LAG) @(posedge clk);
        #1;
        init_done = 1'b1;
        wait (stores >= num_frames * FRAME_WORDS);
        repeat (4) @(posedge clk);
        report_counts();
        if (mismatches + failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* source/video_controller.sv */
`timescale 1ns/1ps

module video_controller (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   init_done_i,
    input  logic [video_mem_pkg::MEM_DATA_W-1:0]   rd_data_i,
    input  logic                                   rd_data_valid_i,
    output logic [video_mem_pkg::MEM_ADDR_W-1:0]   addr_o,
    output logic                                   cmd_o,
    output logic                                   cmd_en_o,
    output logic [video_mem_pkg::MEM_DATA_W-1:0]   wr_data_o,
    output logic                                   load_read_rdy_o,
    output logic [video_mem_pkg::PIXEL_ADDR_W-1:0] load_mem_addr_o,
    input  logic                                   load_pixel_valid_i,
    input  logic [video_mem_pkg::MEM_DATA_W-1:0]   load_pixel_data_i,
    output logic                                   store_wr_en_o,
    input  logic                                   store_queue_full_i,
    output logic [video_mem_pkg::STORE_DATA_W-1:0] store_queue_data_o,
    output logic                                   error_o
);

    import video_mem_pkg::*;
    import frame_buffer_pkg::*;

    logic [NUM_CLIENTS-1:0] req;
    logic [NUM_CLIENTS-1:0] grant;
    logic upload_req;
    logic download_req;
    logic write_req;
    logic read_req;
    logic upload_find;
    logic download_find;
    logic upload_select;
    logic download_select;
    logic upload_release;
    logic download_release;
    logic upload_start;
    logic download_start;
    logic upload_done;
    logic download_done;
    logic mem_wr_en;
    logic mem_rd_en;
    logic [MEM_ADDR_W-1:0] upload_base;
    logic [MEM_ADDR_W-1:0] download_base;
    logic [MEM_ADDR_W-1:0] write_addr;
    logic [MEM_ADDR_W-1:0] read_addr;

    assign req[CLIENT_UPLOAD_SEQ] = upload_req;
    assign req[CLIENT_DOWNLOAD_SEQ] = download_req;
    assign req[CLIENT_WRITER] = write_req;
    assign req[CLIENT_READER] = read_req;

    assign cmd_en_o = mem_wr_en || mem_rd_en;
    assign cmd_o = mem_wr_en ? MEM_CMD_WRITE : MEM_CMD_READ;

    // address from whichever engine owns the memory port
    always_comb begin
        addr_o = '0;
        if (cmd_en_o) begin
            addr_o = grant[CLIENT_WRITER] ? write_addr : read_addr;
        end
    end

    frame_sequencer frame_sequencer0 (
        .clk(clk), .rst_n(rst_n), .init_done_i(init_done_i), .grant_i(grant),
        .upload_done_i(upload_done), .download_done_i(download_done),
        .upload_req_o(upload_req), .download_req_o(download_req),
        .upload_find_o(upload_find), .download_find_o(download_find),
        .upload_select_o(upload_select), .download_select_o(download_select),
        .upload_release_o(upload_release), .download_release_o(download_release),
        .upload_start_o(upload_start), .download_start_o(download_start)
    );

    buffer_table buffer_table0 (
        .clk(clk), .rst_n(rst_n),
        .upload_find_i(upload_find), .download_find_i(download_find),
        .upload_select_i(upload_select), .download_select_i(download_select),
        .upload_release_i(upload_release), .download_release_i(download_release),
        .upload_base_o(upload_base), .download_base_o(download_base), .error_o(error_o)
    );

    access_arbiter access_arbiter0 (
        .clk(clk), .rst_n(rst_n), .req_i(req), .grant_o(grant)
    );

    frame_uploader frame_uploader0 (
        .clk(clk), .rst_n(rst_n), .start_i(upload_start), .grant_i(grant[CLIENT_WRITER]),
        .base_addr_i(upload_base), .load_pixel_valid_i(load_pixel_valid_i),
        .load_pixel_data_i(load_pixel_data_i), .write_req_o(write_req),
        .load_read_rdy_o(load_read_rdy_o), .load_mem_addr_o(load_mem_addr_o),
        .mem_wr_en_o(mem_wr_en), .write_addr_o(write_addr), .write_data_o(wr_data_o),
        .done_o(upload_done)
    );

    frame_downloader frame_downloader0 (
        .clk(clk), .rst_n(rst_n), .start_i(download_start), .grant_i(grant[CLIENT_READER]),
        .base_addr_i(download_base), .rd_data_i(rd_data_i),
        .rd_data_valid_i(rd_data_valid_i), .store_queue_full_i(store_queue_full_i),
        .read_req_o(read_req), .mem_rd_en_o(mem_rd_en), .read_addr_o(read_addr),
        .store_wr_en_o(store_wr_en_o), .store_queue_data_o(store_queue_data_o),
        .done_o(download_done)
    );

endmodule

/* source/frame_downloader.sv */
`timescale 1ns/1ps

module frame_downloader (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start_i,
    input  logic                                   grant_i,
    input  logic [video_mem_pkg::MEM_ADDR_W-1:0]   base_addr_i,
    input  logic [video_mem_pkg::MEM_DATA_W-1:0]   rd_data_i,
    input  logic                                   rd_data_valid_i,
    input  logic                                   store_queue_full_i,
    output logic                                   read_req_o,
    output logic                                   mem_rd_en_o,
    output logic [video_mem_pkg::MEM_ADDR_W-1:0]   read_addr_o,
    output logic                                   store_wr_en_o,
    output logic [video_mem_pkg::STORE_DATA_W-1:0] store_queue_data_o,
    output logic                                   done_o
);

    import video_mem_pkg::*;

    logic active_q;
    logic burst_out_q;
    logic done_q;
    logic [PIXEL_ADDR_W-1:0] issued_q;
    logic [PIXEL_ADDR_W-1:0] recv_q;
    logic word_valid;
    logic last_word;
    logic burst_end;

    assign read_req_o = active_q;
    // full only holds back the next burst
    assign mem_rd_en_o = active_q && grant_i && !burst_out_q && !store_queue_full_i &&
                         (issued_q < PIXEL_ADDR_W'(FRAME_WORDS));
    assign read_addr_o = base_addr_i + MEM_ADDR_W'(issued_q);

    assign word_valid = active_q && rd_data_valid_i;
    assign last_word = (recv_q == PIXEL_ADDR_W'(FRAME_WORDS - 1));
    assign burst_end = ((int'(recv_q) + 1) % MEMORY_BURST) == 0;
    assign store_wr_en_o = word_valid;
    assign store_queue_data_o = {last_word, rd_data_i[STORE_DATA_W-2:0]};
    assign done_o = done_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            burst_out_q <= 1'b0;
            done_q <= 1'b0;
            issued_q <= '0;
            recv_q <= '0;
        end else begin
            done_q <= word_valid && last_word;
            if (start_i) begin
                active_q <= 1'b1;
                burst_out_q <= 1'b0;
                issued_q <= '0;
                recv_q <= '0;
            end else begin
                if (mem_rd_en_o) begin
                    burst_out_q <= 1'b1;
                    issued_q <= issued_q + PIXEL_ADDR_W'(MEMORY_BURST);
                end
                if (word_valid) begin
                    recv_q <= recv_q + 1'b1;
                    if (burst_end) begin
                        burst_out_q <= 1'b0;
                    end
                    if (last_word) begin
                        active_q <= 1'b0;
                    end
                end
            end
        end
    end

    // every word of earlier bursts is back before a new read
    assert property (@(posedge clk) disable iff (!rst_n) mem_rd_en_o |-> recv_q == issued_q);

endmodule

/* source/frame_uploader.sv */
`timescale 1ns/1ps

module frame_uploader (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start_i,
    input  logic                                   grant_i,
    input  logic [video_mem_pkg::MEM_ADDR_W-1:0]   base_addr_i,
    input  logic                                   load_pixel_valid_i,
    input  logic [video_mem_pkg::MEM_DATA_W-1:0]   load_pixel_data_i,
    output logic                                   write_req_o,
    output logic                                   load_read_rdy_o,
    output logic [video_mem_pkg::PIXEL_ADDR_W-1:0] load_mem_addr_o,
    output logic                                   mem_wr_en_o,
    output logic [video_mem_pkg::MEM_ADDR_W-1:0]   write_addr_o,
    output logic [video_mem_pkg::MEM_DATA_W-1:0]   write_data_o,
    output logic                                   done_o
);

    import video_mem_pkg::*;

    logic active_q;
    logic done_q;
    logic [PIXEL_ADDR_W-1:0] pix_idx_q;
    logic last_write;

    assign write_req_o = active_q;
    assign load_read_rdy_o = active_q && grant_i;
    assign load_mem_addr_o = pix_idx_q;

    // one write per valid pixel
    assign mem_wr_en_o = active_q && grant_i && load_pixel_valid_i;
    assign write_addr_o = base_addr_i + MEM_ADDR_W'(pix_idx_q);
    assign write_data_o = load_pixel_data_i;
    assign last_write = mem_wr_en_o && (pix_idx_q == PIXEL_ADDR_W'(FRAME_WORDS - 1));
    assign done_o = done_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            done_q <= 1'b0;
            pix_idx_q <= '0;
        end else begin
            done_q <= last_write;
            if (start_i) begin
                active_q <= 1'b1;
                pix_idx_q <= '0;
            end else if (mem_wr_en_o) begin
                pix_idx_q <= pix_idx_q + 1'b1;
                if (last_write) begin
                    active_q <= 1'b0;
                end
            end
        end
    end

endmodule

/* source/frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     init_done_i,
    input  logic [frame_buffer_pkg::NUM_CLIENTS-1:0] grant_i,
    input  logic                                     upload_done_i,
    input  logic                                     download_done_i,
    output logic                                     upload_req_o,
    output logic                                     download_req_o,
    output logic                                     upload_find_o,
    output logic                                     download_find_o,
    output logic                                     upload_select_o,
    output logic                                     download_select_o,
    output logic                                     upload_release_o,
    output logic                                     download_release_o,
    output logic                                     upload_start_o,
    output logic                                     download_start_o
);

    import video_mem_pkg::*;
    import frame_buffer_pkg::*;

    logic [START_CNT_W-1:0] start_cnt_q;
    logic started;
    seq_state_e upload_state_q;
    seq_state_e upload_state_d;
    seq_state_e download_state_q;
    seq_state_e download_state_d;

    function automatic seq_state_e advance(
        input seq_state_e cur,
        input logic       grant,
        input logic       done
    );
        seq_state_e nxt;
        nxt = cur;
        case (cur)
            IDLE:         nxt = started ? LOCK : START_WAIT;
            START_WAIT:   nxt = started ? LOCK : START_WAIT;
            LOCK:         nxt = grant ? FIND : LOCK;
            FIND:         nxt = SELECT;
            SELECT:       nxt = START_FRAME;
            START_FRAME:  nxt = FRAME_WAIT;
            FRAME_WAIT:   nxt = done ? RELEASE_WAIT : FRAME_WAIT;
            RELEASE_WAIT: nxt = grant ? RELEASE : RELEASE_WAIT;
            default:      nxt = IDLE;
        endcase
        return nxt;
    endfunction

    // table access phases keep the request up
    function automatic logic holds_table(input seq_state_e st);
        return st inside {LOCK, FIND, SELECT, RELEASE_WAIT, RELEASE};
    endfunction

    assign started = (start_cnt_q == START_CNT_W'(MEMORY_INITIAL_DELAY));

    always_comb begin
        upload_state_d = advance(upload_state_q, grant_i[CLIENT_UPLOAD_SEQ], upload_done_i);
        download_state_d = advance(download_state_q, grant_i[CLIENT_DOWNLOAD_SEQ],
                                   download_done_i);
    end

    assign upload_req_o = holds_table(upload_state_q);
    assign download_req_o = holds_table(download_state_q);
    assign upload_find_o = (upload_state_q == FIND);
    assign download_find_o = (download_state_q == FIND);
    assign upload_select_o = (upload_state_q == SELECT);
    assign download_select_o = (download_state_q == SELECT);
    assign upload_release_o = (upload_state_q == RELEASE);
    assign download_release_o = (download_state_q == RELEASE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_cnt_q <= '0;
            upload_state_q <= IDLE;
            download_state_q <= IDLE;
            upload_start_o <= 1'b0;
            download_start_o <= 1'b0;
        end else begin
            // memory settle time
            if (init_done_i && !started) begin
                start_cnt_q <= start_cnt_q + 1'b1;
            end
            upload_state_q <= upload_state_d;
            download_state_q <= download_state_d;
            upload_start_o <= (upload_state_q == SELECT);
            download_start_o <= (download_state_q == SELECT);
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) upload_start_o |=> !upload_start_o);
    assert property (@(posedge clk) disable iff (!rst_n) download_start_o |=> !download_start_o);

endmodule

/* source/buffer_table.sv */
`timescale 1ns/1ps

module buffer_table (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 upload_find_i,
    input  logic                                 download_find_i,
    input  logic                                 upload_select_i,
    input  logic                                 download_select_i,
    input  logic                                 upload_release_i,
    input  logic                                 download_release_i,
    output logic [video_mem_pkg::MEM_ADDR_W-1:0] upload_base_o,
    output logic [video_mem_pkg::MEM_ADDR_W-1:0] download_base_o,
    output logic                                 error_o
);

    import video_mem_pkg::*;
    import frame_buffer_pkg::*;

    buffer_state_e buf_state_q [NUM_BUFFERS];
    logic [BUF_IDX_W-1:0] upload_idx_q;
    logic [BUF_IDX_W-1:0] download_idx_q;
    logic [BUF_IDX_W:0] upload_pick;
    logic [BUF_IDX_W:0] download_pick;

    // msb flags a hit, lowest index in the best state wins
    function automatic logic [BUF_IDX_W:0] pick_buffer(
        input buffer_state_e first,
        input buffer_state_e second,
        input buffer_state_e third
    );
        buffer_state_e prio [3];
        logic [BUF_IDX_W:0] res;
        prio[0] = first;
        prio[1] = second;
        prio[2] = third;
        res = '0;
        for (int p = 2; p >= 0; p--) begin
            for (int b = NUM_BUFFERS - 1; b >= 0; b--) begin
                if (buf_state_q[b] == prio[p]) begin
                    res = {1'b1, BUF_IDX_W'(b)};
                end
            end
        end
        return res;
    endfunction

    always_comb begin
        upload_pick = pick_buffer(DISPLAYED, AVAILABLE, UPDATED);
        download_pick = pick_buffer(UPDATED, AVAILABLE, DISPLAYED);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < NUM_BUFFERS; b++) begin
                buf_state_q[b] <= AVAILABLE;
            end
            upload_idx_q <= '0;
            download_idx_q <= '0;
            error_o <= 1'b0;
        end else begin
            if (upload_find_i) begin
                upload_idx_q <= upload_pick[BUF_IDX_W-1:0];
            end else if (upload_select_i) begin
                buf_state_q[upload_idx_q] <= WRITE_BUSY;
            end else if (upload_release_i) begin
                buf_state_q[upload_idx_q] <= UPDATED;
            end
            if (download_find_i) begin
                download_idx_q <= download_pick[BUF_IDX_W-1:0];
            end else if (download_select_i) begin
                buf_state_q[download_idx_q] <= READ_BUSY;
            end else if (download_release_i) begin
                buf_state_q[download_idx_q] <= DISPLAYED;
            end
            // no candidate buffer, sticky
            if ((upload_find_i && !upload_pick[BUF_IDX_W]) ||
                (download_find_i && !download_pick[BUF_IDX_W])) begin
                error_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upload_select_i) begin
            upload_base_o <= MEM_ADDR_W'(upload_idx_q) * MEM_ADDR_W'(BUFFER_STRIDE);
        end
        if (download_select_i) begin
            download_base_o <= MEM_ADDR_W'(download_idx_q) * MEM_ADDR_W'(BUFFER_STRIDE);
        end
    end

    // index found earlier must not be the one held by the other engine
    assert property (@(posedge clk) disable iff (!rst_n)
        (download_select_i && buf_state_q[upload_idx_q] == WRITE_BUSY)
        |-> download_idx_q != upload_idx_q);
    assert property (@(posedge clk) disable iff (!rst_n)
        (upload_select_i && buf_state_q[download_idx_q] == READ_BUSY)
        |-> upload_idx_q != download_idx_q);

endmodule

/* source/access_arbiter.sv */
`timescale 1ns/1ps

module access_arbiter (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [frame_buffer_pkg::NUM_CLIENTS-1:0] req_i,
    output logic [frame_buffer_pkg::NUM_CLIENTS-1:0] grant_o
);

    import frame_buffer_pkg::*;

    logic [NUM_CLIENTS-1:0] grant_d;
    logic [CLIENT_IDX_W-1:0] last_q;
    logic [CLIENT_IDX_W-1:0] last_d;

    always_comb begin
        logic found;
        int idx;
        found = 1'b0;
        idx = 0;
        grant_d = '0;
        last_d = last_q;
        if (|(grant_o & req_i)) begin
            // owner keeps the grant while it requests
            grant_d = grant_o;
        end else begin
            for (int k = 1; k <= NUM_CLIENTS; k++) begin
                idx = (int'(last_q) + k) % NUM_CLIENTS;
                if (!found && req_i[idx]) begin
                    found = 1'b1;
                    grant_d[idx] = 1'b1;
                    last_d = CLIENT_IDX_W'(idx);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_o <= '0;
            // search begins at client 0
            last_q <= CLIENT_IDX_W'(NUM_CLIENTS - 1);
        end else begin
            grant_o <= grant_d;
            last_q <= last_d;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant_o));

endmodule

/* source/frame_buffer_pkg.sv */
package frame_buffer_pkg;

    localparam int NUM_BUFFERS = 3;
    localparam int BUF_IDX_W = 2;

    typedef enum logic [2:0] {
        AVAILABLE,
        WRITE_BUSY,
        READ_BUSY,
        UPDATED,
        DISPLAYED
    } buffer_state_e;

    typedef enum logic [3:0] {
        IDLE,
        START_WAIT,
        LOCK,
        FIND,
        SELECT,
        START_FRAME,
        FRAME_WAIT,
        RELEASE_WAIT,
        RELEASE
    } seq_state_e;

    // clients of the shared table and memory port
    localparam int NUM_CLIENTS = 4;
    localparam int CLIENT_IDX_W = 2;
    localparam int CLIENT_UPLOAD_SEQ = 0;
    localparam int CLIENT_DOWNLOAD_SEQ = 1;
    localparam int CLIENT_WRITER = 2;
    localparam int CLIENT_READER = 3;

endpackage

/* source/video_mem_pkg.sv */
package video_mem_pkg;

    localparam int FRAME_WIDTH = 16;
    localparam int FRAME_HEIGHT = 4;
    // one pixel per memory word
    localparam int FRAME_WORDS = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int BUFFER_GUARD = 32;
    localparam int BUFFER_STRIDE = FRAME_WORDS + BUFFER_GUARD;

    localparam int MEM_ADDR_W = 21;
    localparam int MEM_DATA_W = 32;
    localparam int PIXEL_ADDR_W = 10;
    // 16 pixel bits plus end of frame flag
    localparam int STORE_DATA_W = 17;

    // words per read burst
    localparam int MEMORY_BURST = 8;
    localparam int MEMORY_INITIAL_DELAY = 152;
    localparam int START_CNT_W = 8;

    typedef enum logic {
        MEM_CMD_READ  = 1'b0,
        MEM_CMD_WRITE = 1'b1
    } mem_cmd_e;

endpackage
